// File: hw/seg_pkg.sv
package seg_pkg;

	localparam int ADDR_W     = 5;
	localparam int DATA_W     = 32;
	localparam int STRB_W     = DATA_W / 8;
	localparam int NUM_DIGITS = 6;
	localparam int DIGIT_W    = 4;
	localparam int SEG_W      = 7;

	// Register map, byte offsets
	localparam logic [ADDR_W-1:0] DIGIT_OFF_0 = 5'h00;
	localparam logic [ADDR_W-1:0] DIGIT_OFF_1 = 5'h04;
	localparam logic [ADDR_W-1:0] DIGIT_OFF_2 = 5'h08;
	localparam logic [ADDR_W-1:0] DIGIT_OFF_3 = 5'h0C;
	localparam logic [ADDR_W-1:0] DIGIT_OFF_4 = 5'h10;
	localparam logic [ADDR_W-1:0] DIGIT_OFF_5 = 5'h14;
	localparam logic [ADDR_W-1:0] CTRL_OFF    = 5'h18;

	localparam logic [NUM_DIGITS-1:0] CTRL_EN_RESET = 6'b111111;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// 16 suits simulation; a board build sets a much larger value
	localparam int                     BLINK_CNT_W       = 5;
	localparam logic [BLINK_CNT_W-1:0] BLINK_HALF_PERIOD = 5'd16;

	typedef enum logic [2:0] {
		IDLE,
		W_ADDR,     // W taken, waiting for AW
		W_DATA,     // AW taken, waiting for W
		W_RESP,
		R_RESP
	} axil_state_t;

	typedef struct packed {
		logic              wr_en;
		logic [ADDR_W-1:0] wr_addr;
		logic [DATA_W-1:0] wr_data;
		logic [STRB_W-1:0] wr_strb;
		logic [ADDR_W-1:0] rd_addr;
	} reg_req_t;

	// Digit 0 sits in the lowest bits
	typedef struct packed {
		logic [SEG_W-1:0] hex5;
		logic [SEG_W-1:0] hex4;
		logic [SEG_W-1:0] hex3;
		logic [SEG_W-1:0] hex2;
		logic [SEG_W-1:0] hex1;
		logic [SEG_W-1:0] hex0;
	} seg_out_t;

endpackage : seg_pkg

// File: hw/blink_timer.sv
`timescale 1ns/1ps

module blink_timer (
	input  logic clk,
	input  logic rst,
	output logic phase_o
);

	logic [seg_pkg::BLINK_CNT_W-1:0] cnt_q;
	logic                            phase_q;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cnt_q   <= '0;
			phase_q <= 1'b0;    // Starts "on"
		end else if (cnt_q == seg_pkg::BLINK_HALF_PERIOD - 1'b1) begin
			cnt_q   <= '0;
			phase_q <= ~phase_q;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign phase_o = phase_q;

	a_cnt_range: assert property (@(posedge clk) disable iff (rst)
		cnt_q < seg_pkg::BLINK_HALF_PERIOD);

endmodule : blink_timer

// File: hw/hex7seg.sv
`timescale 1ns/1ps

module hex7seg (
	input  logic [3:0] digit_i,
	input  logic       blank_i,
	output logic [6:0] seg_o
);

	// Active low, bit 0 is segment a
	always_comb begin
		if (blank_i) begin
			seg_o = 7'h7F;
		end else begin
			unique case (digit_i)
				4'h0: seg_o = 7'h40;
				4'h1: seg_o = 7'h79;
				4'h2: seg_o = 7'h24;
				4'h3: seg_o = 7'h30;
				4'h4: seg_o = 7'h19;
				4'h5: seg_o = 7'h12;
				4'h6: seg_o = 7'h02;
				4'h7: seg_o = 7'h78;
				4'h8: seg_o = 7'h00;
				4'h9: seg_o = 7'h10;
				4'hA: seg_o = 7'h08;
				4'hB: seg_o = 7'h03;    // Lower case b
				4'hC: seg_o = 7'h46;
				4'hD: seg_o = 7'h21;    // Lower case d
				4'hE: seg_o = 7'h06;
				4'hF: seg_o = 7'h0E;
			endcase
		end
	end

endmodule : hex7seg

// File: hw/seg_regfile.sv
`timescale 1ns/1ps

module seg_regfile (
	input  logic                                                clk,
	input  logic                                                rst,
	input  seg_pkg::reg_req_t                                   req_i,
	input  logic                                                blink_phase_i,
	output logic [seg_pkg::DATA_W-1:0]                          rd_data_o,
	output logic                                                rd_err_o,
	output logic                                                wr_err_o,
	output logic [seg_pkg::NUM_DIGITS-1:0][seg_pkg::DIGIT_W-1:0] digit_o,
	output logic [seg_pkg::NUM_DIGITS-1:0]                      blank_o
);

	logic [seg_pkg::NUM_DIGITS-1:0][seg_pkg::DIGIT_W-1:0] digit_q;
	logic [seg_pkg::NUM_DIGITS-1:0]                       en_q, blink_q;
	logic [seg_pkg::NUM_DIGITS:0]                         wr_sel, rd_sel;

	// One-hot select, digits in the low bits and control on top
	function automatic logic [seg_pkg::NUM_DIGITS:0] addr_sel(
		input logic [seg_pkg::ADDR_W-1:0] addr
	);
		logic [seg_pkg::NUM_DIGITS:0] sel;
		sel = '0;
		case (addr)
			seg_pkg::DIGIT_OFF_0: sel[0] = 1'b1;
			seg_pkg::DIGIT_OFF_1: sel[1] = 1'b1;
			seg_pkg::DIGIT_OFF_2: sel[2] = 1'b1;
			seg_pkg::DIGIT_OFF_3: sel[3] = 1'b1;
			seg_pkg::DIGIT_OFF_4: sel[4] = 1'b1;
			seg_pkg::DIGIT_OFF_5: sel[5] = 1'b1;
			seg_pkg::CTRL_OFF:    sel[seg_pkg::NUM_DIGITS] = 1'b1;
			default:              sel = '0;    // 0x1C and misaligned
		endcase
		return sel;
	endfunction

	assign wr_sel   = addr_sel(req_i.wr_addr);
	assign rd_sel   = addr_sel(req_i.rd_addr);
	assign wr_err_o = ~|wr_sel;
	assign rd_err_o = ~|rd_sel;

	always_comb begin
		rd_data_o = '0;
		for (int i = 0; i < seg_pkg::NUM_DIGITS; i++) begin
			if (rd_sel[i])
				rd_data_o[seg_pkg::DIGIT_W-1:0] = digit_q[i];
		end
		if (rd_sel[seg_pkg::NUM_DIGITS]) begin
			rd_data_o[5:0]  = en_q;
			rd_data_o[13:8] = blink_q;
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			digit_q <= '0;
			en_q    <= seg_pkg::CTRL_EN_RESET;
			blink_q <= '0;
		end else if (req_i.wr_en && !wr_err_o) begin
			for (int i = 0; i < seg_pkg::NUM_DIGITS; i++) begin
				if (wr_sel[i] && req_i.wr_strb[0])
					digit_q[i] <= req_i.wr_data[seg_pkg::DIGIT_W-1:0];
			end
			if (wr_sel[seg_pkg::NUM_DIGITS]) begin
				if (req_i.wr_strb[0])
					en_q <= req_i.wr_data[5:0];    // Enable mask
				if (req_i.wr_strb[1])
					blink_q <= req_i.wr_data[13:8];    // Blink mask
			end
		end
	end

	assign digit_o = digit_q;
	assign blank_o = ~en_q | (blink_q & {seg_pkg::NUM_DIGITS{blink_phase_i}});

	// A write is applied once
	a_wr_en_pulse: assert property (@(posedge clk) disable iff (rst)
		req_i.wr_en |=> !req_i.wr_en);

endmodule : seg_regfile

// File: hw/axil_slave_fsm.sv
`timescale 1ns/1ps

module axil_slave_fsm (
	input  logic                           clk,
	input  logic                           rst,

	input  logic                           s_awvalid_i,
	input  logic [seg_pkg::ADDR_W-1:0]     s_awaddr_i,
	output logic                           s_awready_o,
	input  logic                           s_wvalid_i,
	input  logic [seg_pkg::DATA_W-1:0]     s_wdata_i,
	input  logic [seg_pkg::STRB_W-1:0]     s_wstrb_i,
	output logic                           s_wready_o,
	output logic                           s_bvalid_o,
	output logic [1:0]                     s_bresp_o,
	input  logic                           s_bready_i,
	input  logic                           s_arvalid_i,
	input  logic [seg_pkg::ADDR_W-1:0]     s_araddr_i,
	output logic                           s_arready_o,
	output logic                           s_rvalid_o,
	output logic [seg_pkg::DATA_W-1:0]     s_rdata_o,
	output logic [1:0]                     s_rresp_o,
	input  logic                           s_rready_i,

	output seg_pkg::reg_req_t              req_o,
	input  logic [seg_pkg::DATA_W-1:0]     rd_data_i,
	input  logic                           rd_err_i,
	input  logic                           wr_err_i
);

	seg_pkg::axil_state_t state_q, state_d;

	logic [seg_pkg::ADDR_W-1:0] aw_addr_q, rd_addr_q;
	logic [seg_pkg::DATA_W-1:0] wdata_q, rdata_q;
	logic [seg_pkg::STRB_W-1:0] wstrb_q;
	logic [1:0]                 bresp_q, rresp_q;
	logic                       wr_en_q, bvalid_q, rvalid_q;
	logic                       wr_start;
	logic                       rd_fetch;
	logic                       aw_hs, w_hs, ar_hs, b_hs, r_hs;

	// Reads win in IDLE
	assign s_arready_o = (state_q == seg_pkg::IDLE) && s_arvalid_i;
	assign s_awready_o = s_awvalid_i && (((state_q == seg_pkg::IDLE) && !s_arvalid_i) ||
		(state_q == seg_pkg::W_ADDR));
	assign s_wready_o  = s_wvalid_i && (((state_q == seg_pkg::IDLE) && !s_arvalid_i) ||
		(state_q == seg_pkg::W_DATA));

	assign aw_hs = s_awvalid_i && s_awready_o;
	assign w_hs  = s_wvalid_i && s_wready_o;
	assign ar_hs = s_arvalid_i && s_arready_o;
	assign b_hs  = s_bvalid_o && s_bready_i;
	assign r_hs  = s_rvalid_o && s_rready_i;

	// First R_RESP cycle, register data is fetched
	assign rd_fetch = (state_q == seg_pkg::R_RESP) && !rvalid_q;

	always_comb begin
		state_d  = state_q;
		wr_start = 1'b0;
		unique case (state_q)
			seg_pkg::IDLE: begin
				if (ar_hs) begin
					state_d = seg_pkg::R_RESP;
				end else if (aw_hs && w_hs) begin
					state_d  = seg_pkg::W_RESP;
					wr_start = 1'b1;
				end else if (aw_hs) begin
					state_d = seg_pkg::W_DATA;
				end else if (w_hs) begin
					state_d = seg_pkg::W_ADDR;
				end
			end
			seg_pkg::W_ADDR: begin
				if (aw_hs) begin
					state_d  = seg_pkg::W_RESP;
					wr_start = 1'b1;
				end
			end
			seg_pkg::W_DATA: begin
				if (w_hs) begin
					state_d  = seg_pkg::W_RESP;
					wr_start = 1'b1;
				end
			end
			seg_pkg::W_RESP: if (b_hs) state_d = seg_pkg::IDLE;
			seg_pkg::R_RESP: if (r_hs) state_d = seg_pkg::IDLE;
			default:         state_d = seg_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q  <= seg_pkg::IDLE;
			wr_en_q  <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			wr_en_q <= wr_start;    // one-cycle pulse
			if (wr_en_q)
				bvalid_q <= 1'b1;
			else if (b_hs)
				bvalid_q <= 1'b0;
			if (rd_fetch)
				rvalid_q <= 1'b1;
			else if (r_hs)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			aw_addr_q <= s_awaddr_i;
		if (w_hs) begin
			wdata_q <= s_wdata_i;
			wstrb_q <= s_wstrb_i;
		end
		if (wr_en_q)
			bresp_q <= wr_err_i ? seg_pkg::RESP_SLVERR : seg_pkg::RESP_OKAY;
		if (ar_hs)
			rd_addr_q <= s_araddr_i;
		if (rd_fetch) begin
			rdata_q <= rd_data_i;
			rresp_q <= rd_err_i ? seg_pkg::RESP_SLVERR : seg_pkg::RESP_OKAY;
		end
	end

	always_comb begin
		req_o.wr_en   = wr_en_q;
		req_o.wr_addr = aw_addr_q;
		req_o.wr_data = wdata_q;
		req_o.wr_strb = wstrb_q;
		req_o.rd_addr = rd_addr_q;    // Held from the AR handshake
	end

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = bresp_q;
	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = rresp_q;

	a_resp_excl: assert property (@(posedge clk) disable iff (rst)
		!(s_bvalid_o && s_rvalid_o));

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		(s_bvalid_o && !s_bready_i) |=> (s_bvalid_o && $stable(s_bresp_o)));

	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		(s_rvalid_o && !s_rready_i) |=> (s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o)));

endmodule : axil_slave_fsm

// File: hw/seg_display_top.sv
`timescale 1ns/1ps

module seg_display_top (
	input  logic                        clk,
	input  logic                        rst,

	input  logic                        s_awvalid_i,
	input  logic [seg_pkg::ADDR_W-1:0]  s_awaddr_i,
	output logic                        s_awready_o,
	input  logic                        s_wvalid_i,
	input  logic [seg_pkg::DATA_W-1:0]  s_wdata_i,
	input  logic [seg_pkg::STRB_W-1:0]  s_wstrb_i,
	output logic                        s_wready_o,
	output logic                        s_bvalid_o,
	output logic [1:0]                  s_bresp_o,
	input  logic                        s_bready_i,
	input  logic                        s_arvalid_i,
	input  logic [seg_pkg::ADDR_W-1:0]  s_araddr_i,
	output logic                        s_arready_o,
	output logic                        s_rvalid_o,
	output logic [seg_pkg::DATA_W-1:0]  s_rdata_o,
	output logic [1:0]                  s_rresp_o,
	input  logic                        s_rready_i,

	output seg_pkg::seg_out_t           hex_o
);

	seg_pkg::reg_req_t                                    req;
	logic [seg_pkg::DATA_W-1:0]                           rd_data;
	logic                                                 rd_err, wr_err;
	logic                                                 blink_phase;
	logic [seg_pkg::NUM_DIGITS-1:0][seg_pkg::DIGIT_W-1:0] digit_val;
	logic [seg_pkg::NUM_DIGITS-1:0]                       blank;

	axil_slave_fsm i_axil_slave_fsm (
		.clk         (clk),
		.rst         (rst),
		.s_awvalid_i (s_awvalid_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awready_o (s_awready_o),
		.s_wvalid_i  (s_wvalid_i),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_wready_o  (s_wready_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bresp_o   (s_bresp_o),
		.s_bready_i  (s_bready_i),
		.s_arvalid_i (s_arvalid_i),
		.s_araddr_i  (s_araddr_i),
		.s_arready_o (s_arready_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rready_i  (s_rready_i),
		.req_o       (req),
		.rd_data_i   (rd_data),
		.rd_err_i    (rd_err),
		.wr_err_i    (wr_err)
	);

	seg_regfile i_seg_regfile (
		.clk           (clk),
		.rst           (rst),
		.req_i         (req),
		.blink_phase_i (blink_phase),
		.rd_data_o     (rd_data),
		.rd_err_o      (rd_err),
		.wr_err_o      (wr_err),
		.digit_o       (digit_val),
		.blank_o       (blank)
	);

	blink_timer i_blink_timer (
		.clk     (clk),
		.rst     (rst),
		.phase_o (blink_phase)
	);

	// Six displays wired in parallel, no scanning
	for (genvar i = 0; i < seg_pkg::NUM_DIGITS; i++) begin : g_digit
		hex7seg i_hex7seg (
			.digit_i (digit_val[i]),
			.blank_i (blank[i]),
			.seg_o   (hex_o[i*seg_pkg::SEG_W +: seg_pkg::SEG_W])
		);
	end

endmodule : seg_display_top

// File: verif/tb_seg_display.sv
`timescale 1ns/1ps

module tb_seg_display;

	localparam int HALF = int'(seg_pkg::BLINK_HALF_PERIOD);

	// Lit segments per hex value, gfedcba, active high
	localparam logic [6:0] SEG_LIT [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	typedef struct packed {
		logic        is_rd;
		logic [4:0]  addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [1:0]  exp_resp;
		logic [31:0] exp_rdata;
	} entry_t;

	logic                              clk;
	logic                              rst;
	logic                              s_awvalid_i, s_wvalid_i, s_bready_i;
	logic                              s_arvalid_i, s_rready_i;
	logic [seg_pkg::ADDR_W-1:0]        s_awaddr_i, s_araddr_i;
	logic [seg_pkg::DATA_W-1:0]        s_wdata_i;
	logic [seg_pkg::STRB_W-1:0]        s_wstrb_i;
	logic                              s_awready_o, s_wready_o, s_bvalid_o;
	logic                              s_arready_o, s_rvalid_o;
	logic [1:0]                        s_bresp_o, s_rresp_o;
	logic [seg_pkg::DATA_W-1:0]        s_rdata_o;
	seg_pkg::seg_out_t                 hex_o;

	entry_t     tbl [$];
	logic [3:0] sh_digit [6];
	logic [5:0] sh_en, sh_blink;
	int         cycles = 0;
	int         limit;

	seg_display_top i_seg_display_top (
		.clk         (clk),
		.rst         (rst),
		.s_awvalid_i (s_awvalid_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awready_o (s_awready_o),
		.s_wvalid_i  (s_wvalid_i),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_wready_o  (s_wready_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bresp_o   (s_bresp_o),
		.s_bready_i  (s_bready_i),
		.s_arvalid_i (s_arvalid_i),
		.s_araddr_i  (s_araddr_i),
		.s_arready_o (s_arready_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rready_i  (s_rready_i),
		.hex_o       (hex_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst) begin
			cycles <= cycles + 1;
			if (cycles >= limit) begin
				$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
				$display("Verification failed");
				$fatal(1, "timeout");
			end
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
		$display("Verification failed");
		$fatal(1, "value check");
	endtask

	task automatic add_entry(input logic is_rd, input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] exp_resp, input logic [31:0] exp_rdata);
		entry_t e;
		e.is_rd     = is_rd;
		e.addr      = addr;
		e.data      = data;
		e.strb      = strb;
		e.exp_resp  = exp_resp;
		e.exp_rdata = exp_rdata;
		tbl.push_back(e);
	endtask

	function automatic void shadow_write(input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int idx;
		idx = int'(addr >> 2);
		if (addr[1:0] != 2'b00 || addr > seg_pkg::CTRL_OFF)
			return;    // Unmapped, nothing changes
		if (addr == seg_pkg::CTRL_OFF) begin
			if (strb[0])
				sh_en = data[5:0];
			if (strb[1])
				sh_blink = data[13:8];
		end else if (strb[0]) begin
			sh_digit[idx] = data[3:0];
		end
	endfunction

	function automatic logic [41:0] model_hex(input logic [5:0] blank);
		logic [41:0] v;
		v = '0;
		for (int i = 0; i < 6; i++)
			v[i*7 +: 7] = blank[i] ? 7'h7F : ~SEG_LIT[sh_digit[i]];
		return v;
	endfunction

	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int         order;
		int         stall;
		bit         aw_done;
		bit         w_done;
		logic [1:0] held;
		order   = $urandom_range(0, 2);    // 0 together, 1 AW first, 2 W first
		stall   = $urandom_range(0, 3);
		aw_done = 1'b0;
		w_done  = 1'b0;
		while (!(aw_done && w_done)) begin
			@(posedge clk);
			s_awaddr_i  <= addr;
			s_wdata_i   <= data;
			s_wstrb_i   <= strb;
			s_awvalid_i <= !aw_done && (order != 2 || w_done);
			s_wvalid_i  <= !w_done && (order != 1 || aw_done);
			@(negedge clk);
			if (s_awvalid_i && s_awready_o)
				aw_done = 1'b1;
			if (s_wvalid_i && s_wready_o)
				w_done = 1'b1;
		end
		@(posedge clk);
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		@(negedge clk);
		while (!s_bvalid_o)
			@(negedge clk);
		held = s_bresp_o;
		repeat (stall) begin
			@(negedge clk);
			assert (s_bvalid_o) else report_mismatch("s_bvalid_o", 64'(s_bvalid_o), 64'(1));
			assert (s_bresp_o == held) else report_mismatch("s_bresp_o", 64'(s_bresp_o), 64'(held));
		end
		@(posedge clk);
		s_bready_i <= 1'b1;
		@(negedge clk);
		assert (s_bvalid_o) else report_mismatch("s_bvalid_o", 64'(s_bvalid_o), 64'(1));
		resp = s_bresp_o;
		@(posedge clk);
		s_bready_i <= 1'b0;
	endtask

	task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int          stall;
		logic [31:0] held;
		stall = $urandom_range(0, 3);
		@(posedge clk);
		s_araddr_i  <= addr;
		s_arvalid_i <= 1'b1;
		@(negedge clk);
		while (!s_arready_o)
			@(negedge clk);
		@(posedge clk);
		s_arvalid_i <= 1'b0;
		@(negedge clk);
		while (!s_rvalid_o)
			@(negedge clk);
		held = s_rdata_o;
		repeat (stall) begin
			@(negedge clk);
			assert (s_rvalid_o) else report_mismatch("s_rvalid_o", 64'(s_rvalid_o), 64'(1));
			assert (s_rdata_o == held) else report_mismatch("s_rdata_o", 64'(s_rdata_o), 64'(held));
		end
		@(posedge clk);
		s_rready_i <= 1'b1;
		@(negedge clk);
		assert (s_rvalid_o) else report_mismatch("s_rvalid_o", 64'(s_rvalid_o), 64'(1));
		data = s_rdata_o;
		resp = s_rresp_o;
		@(posedge clk);
		s_rready_i <= 1'b0;
	endtask

	task automatic check_hex();
		@(negedge clk);
		assert (hex_o == model_hex(~sh_en))
			else report_mismatch("hex_o", 64'(hex_o), 64'(model_hex(~sh_en)));
	endtask

	task automatic run_entry(input entry_t e);
		logic [1:0]  resp;
		logic [31:0] rdata;
		logic [31:0] rnd;
		logic [31:0] wdata;
		if (e.is_rd) begin
			axi_read(e.addr, rdata, resp);
			assert (resp == e.exp_resp) else report_mismatch("s_rresp_o", 64'(resp), 64'(e.exp_resp));
			assert (rdata == e.exp_rdata)
				else report_mismatch("s_rdata_o", 64'(rdata), 64'(e.exp_rdata));
		end else begin
			rnd   = $urandom();
			wdata = (e.addr < seg_pkg::CTRL_OFF) ? {rnd[31:4], e.data[3:0]} : e.data;    // Junk above nibble
			axi_write(e.addr, wdata, e.strb, resp);
			assert (resp == e.exp_resp) else report_mismatch("s_bresp_o", 64'(resp), 64'(e.exp_resp));
			shadow_write(e.addr, wdata, e.strb);
		end
		check_hex();
	endtask

	// Every blinking digit spends half of any 4-half-period window dark
	task automatic check_blink();
		int          on_cnt [6];
		int          off_cnt [6];
		logic [41:0] lit;
		logic [41:0] hex;
		lit = model_hex(6'b0);
		for (int i = 0; i < 6; i++) begin
			on_cnt[i]  = 0;
			off_cnt[i] = 0;
		end
		repeat (4 * HALF) begin
			@(negedge clk);
			hex = hex_o;
			for (int i = 0; i < 6; i++) begin
				if (sh_blink[i] && hex[i*7 +: 7] == 7'h7F) begin
					off_cnt[i]++;
				end else begin
					assert (hex[i*7 +: 7] == lit[i*7 +: 7]) else report_mismatch(
						$sformatf("hex_o digit %0d", i), 64'(hex[i*7 +: 7]), 64'(lit[i*7 +: 7]));
					on_cnt[i]++;
				end
			end
		end
		for (int i = 0; i < 6; i++) begin
			if (sh_blink[i]) begin
				assert (on_cnt[i] == 2 * HALF) else report_mismatch(
					$sformatf("lit cycles digit %0d", i), 64'(on_cnt[i]), 64'(2 * HALF));
				assert (off_cnt[i] == 2 * HALF) else report_mismatch(
					$sformatf("blank cycles digit %0d", i), 64'(off_cnt[i]), 64'(2 * HALF));
			end
		end
	endtask

	initial begin
		logic [1:0]  resp;
		logic [31:0] rdata;
		logic [31:0] rnd;
		void'($urandom(97));
		rst         <= 1'b1;
		s_awvalid_i <= 1'b0;
		s_awaddr_i  <= '0;
		s_wvalid_i  <= 1'b0;
		s_wdata_i   <= '0;
		s_wstrb_i   <= '0;
		s_bready_i  <= 1'b0;
		s_arvalid_i <= 1'b0;
		s_araddr_i  <= '0;
		s_rready_i  <= 1'b0;
		for (int i = 0; i < 6; i++)
			sh_digit[i] = 4'h0;
		sh_en    = 6'h3F;
		sh_blink = 6'h00;

		for (int i = 0; i < 6; i++)
			add_entry(1'b1, 5'(4 * i), 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h18, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h3F);
		add_entry(1'b0, 5'h00, 32'hA, 4'hF, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h00, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'hA);
		add_entry(1'b0, 5'h04, 32'h5, 4'hF, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h04, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h5);
		add_entry(1'b0, 5'h08, 32'hC, 4'h1, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h08, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'hC);
		add_entry(1'b0, 5'h0C, 32'h7, 4'hF, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h0C, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h7);
		add_entry(1'b0, 5'h10, 32'hE, 4'h3, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h10, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'hE);
		add_entry(1'b0, 5'h14, 32'h9, 4'hF, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h14, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h9);
		add_entry(1'b0, 5'h1C, 32'hF, 4'hF, seg_pkg::RESP_SLVERR, 32'h0);
		add_entry(1'b0, 5'h02, 32'h1, 4'hF, seg_pkg::RESP_SLVERR, 32'h0);
		add_entry(1'b0, 5'h19, 32'h0, 4'hF, seg_pkg::RESP_SLVERR, 32'h0);
		add_entry(1'b1, 5'h1C, 32'h0, 4'h0, seg_pkg::RESP_SLVERR, 32'h0);
		add_entry(1'b1, 5'h06, 32'h0, 4'h0, seg_pkg::RESP_SLVERR, 32'h0);
		add_entry(1'b0, 5'h00, 32'h3, 4'hE, seg_pkg::RESP_OKAY, 32'h0);    // Strobe 0 clear
		add_entry(1'b1, 5'h00, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'hA);
		add_entry(1'b1, 5'h18, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h3F);
		add_entry(1'b0, 5'h18, 32'h2D, 4'h1, seg_pkg::RESP_OKAY, 32'h0);    // Digits 1 and 4 off
		add_entry(1'b1, 5'h18, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h2D);
		add_entry(1'b0, 5'h18, 32'h1F3F, 4'h1, seg_pkg::RESP_OKAY, 32'h0);
		add_entry(1'b1, 5'h18, 32'h0, 4'h0, seg_pkg::RESP_OKAY, 32'h3F);

		// Worst case about 12 cycles per bus operation, plus the blink window
		limit = (tbl.size() + 2 * seg_pkg::NUM_DIGITS + 1) * 12 + 200 + 4 * HALF;

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!s_bvalid_o && !s_rvalid_o && !s_arready_o && !s_awready_o && !s_wready_o)
			else report_mismatch("ready and valid outputs", 64'({s_bvalid_o, s_rvalid_o,
				s_arready_o, s_awready_o, s_wready_o}), 64'(0));
		check_hex();

		foreach (tbl[k])
			run_entry(tbl[k]);

		for (int i = 0; i < 6; i++) begin
			rnd = $urandom();
			axi_write(5'(4 * i), rnd, 4'hF, resp);
			assert (resp == seg_pkg::RESP_OKAY)
				else report_mismatch("s_bresp_o", 64'(resp), 64'(seg_pkg::RESP_OKAY));
			shadow_write(5'(4 * i), rnd, 4'hF);
			axi_read(5'(4 * i), rdata, resp);
			assert (resp == seg_pkg::RESP_OKAY)
				else report_mismatch("s_rresp_o", 64'(resp), 64'(seg_pkg::RESP_OKAY));
			assert (rdata == {28'h0, rnd[3:0]})
				else report_mismatch("s_rdata_o", 64'(rdata), 64'({28'h0, rnd[3:0]}));
			check_hex();
		end

		axi_write(seg_pkg::CTRL_OFF, 32'h0A3F, 4'h3, resp);    // Digits 1 and 3 blink
		assert (resp == seg_pkg::RESP_OKAY)
			else report_mismatch("s_bresp_o", 64'(resp), 64'(seg_pkg::RESP_OKAY));
		shadow_write(seg_pkg::CTRL_OFF, 32'h0A3F, 4'h3);
		@(negedge clk);
		check_blink();

		$display("Verification passed");
		$finish;
	end

endmodule : tb_seg_display

// File: files.f
hw/seg_pkg.sv
hw/blink_timer.sv
hw/hex7seg.sv
hw/seg_regfile.sv
hw/axil_slave_fsm.sv
hw/seg_display_top.sv
verif/tb_seg_display.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_seg_display
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
